/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = telemetry_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log

SOURCES   = $(shell grep -v '^+' $(FILELIST)) common/telemetry_settings.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '^Test OK$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/telemetry_pkg.sv */
`default_nettype none

`include "telemetry_settings.svh"

package telemetry_pkg;

    typedef logic [`TELE_SIG_W-1:0] tele_sig_t;     // Protocol status vector
    typedef logic [`TELE_IGN_W-1:0] tele_ign_t;     // Frame number and CRC error bit
    typedef logic [`TELE_SIG_W+`TELE_IGN_W-1:0] tele_word_t;
    typedef logic [`TELE_ADDR_W-1:0] tele_addr_t;
    typedef logic [`TELE_ADDR_W:0] tele_level_t;    // Extra bit so a full SRAM fits
    typedef logic [7:0] tele_char_t;

    typedef enum logic [2:0] {
        DUMP_IDLE,
        DUMP_REQ,
        DUMP_WAIT,
        DUMP_NIBBLE,
        DUMP_NEWLINE
    } dump_state_t;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

endpackage

`default_nettype wire

/* common/telemetry_settings.svh */
`ifndef TELEMETRY_SETTINGS_SVH
`define TELEMETRY_SETTINGS_SVH

// Telemetry SRAM geometry
`define TELE_DEPTH 16
`define TELE_ADDR_W 4

// Field widths of one stored word
`define TELE_SIG_W 20
`define TELE_IGN_W 12

// UART bit period in clock cycles
// Hardware at 60 MHz and 230400 baud would need about 260
`define TELE_CLKS_PER_BIT 8

`endif

/* filelist.f */
+incdir+common
common/telemetry_pkg.sv
source/change_logger.sv
source/sram_arbiter.sv
source/telemetry_sram.sv
hex_dump/hex_dump.sv
source/uart_tx.sv
source/telemetry_top.sv
tests/telemetry_tb.sv

/* hex_dump/hex_dump.sv */
`timescale 1ns/1ps
`default_nettype none

module hex_dump
    import telemetry_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        arst_n_i,
    input  wire logic        start_dump_i,
    input  wire tele_level_t wr_ptr_i,
    output logic             rd_req_o,
    output tele_addr_t       rd_addr_o,
    input  wire logic        rd_gnt_i,
    input  wire tele_word_t  rd_data_i,
    output tele_level_t      rd_ptr_o,
    output logic             is_dumping_o,
    output logic             char_valid_o,
    output tele_char_t       char_data_o,
    input  wire logic        char_ready_i
);

    localparam int WORD_W = $bits(tele_word_t);
    localparam tele_char_t NEWLINE = 8'h0A;

    dump_state_t state_q;
    tele_level_t rd_ptr_q;
    tele_level_t end_ptr_q;     // Write pointer captured at the start pulse
    tele_word_t  word_q;
    logic [2:0]  nib_cnt_q;
    logic        drained;
    logic        char_fire;

    function automatic tele_char_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};     // '0' to '9'
        end
        return 8'h37 + {4'h0, nib};         // 'A' to 'F'
    endfunction

    assign drained   = rd_ptr_q == end_ptr_q;
    assign char_fire = char_valid_o && char_ready_i;

    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= DUMP_IDLE;
            rd_ptr_q  <= '0;
            end_ptr_q <= '0;
            nib_cnt_q <= '0;
        end else begin
            case (state_q)
                DUMP_IDLE: begin
                    if (start_dump_i) begin
                        end_ptr_q <= wr_ptr_i;
                        state_q   <= DUMP_REQ;
                    end
                end
                DUMP_REQ: begin
                    if (drained) begin
                        state_q <= DUMP_IDLE;   // Nothing was stored
                    end else if (rd_gnt_i) begin
                        state_q <= DUMP_WAIT;
                    end
                end
                DUMP_WAIT: begin
                    rd_ptr_q  <= rd_ptr_q + tele_level_t'(1);  // Slot is free once copied
                    nib_cnt_q <= '0;
                    state_q   <= DUMP_NIBBLE;
                end
                DUMP_NIBBLE: begin
                    if (char_fire) begin
                        nib_cnt_q <= nib_cnt_q + 3'd1;
                        if (nib_cnt_q == 3'd7) begin
                            state_q <= DUMP_NEWLINE;
                        end
                    end
                end
                DUMP_NEWLINE: begin
                    if (char_fire) begin
                        state_q <= drained ? DUMP_IDLE : DUMP_REQ;
                    end
                end
                default: state_q <= DUMP_IDLE;
            endcase
        end
    end

    // Word buffer, most significant nibble goes out first
    always_ff @(posedge clock) begin
        if (state_q == DUMP_WAIT) begin
            word_q <= rd_data_i;
        end else if (state_q == DUMP_NIBBLE && char_fire) begin
            word_q <= word_q << 4;
        end
    end

    assign rd_req_o  = (state_q == DUMP_REQ) && !drained;
    assign rd_addr_o = rd_ptr_q[$bits(tele_addr_t)-1:0];
    assign rd_ptr_o  = rd_ptr_q;

    assign is_dumping_o = state_q != DUMP_IDLE;
    assign char_valid_o = (state_q == DUMP_NIBBLE) || (state_q == DUMP_NEWLINE);
    assign char_data_o  = (state_q == DUMP_NEWLINE) ? NEWLINE : hex_char(word_q[WORD_W-1 -: 4]);

endmodule

`default_nettype wire

/* source/change_logger.sv */
`timescale 1ns/1ps
`default_nettype none

`include "telemetry_settings.svh"

module change_logger
    import telemetry_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        arst_n_i,
    input  wire logic        enable_i,
    input  wire tele_sig_t   change_i,
    input  wire tele_ign_t   ignore_i,
    input  wire tele_level_t rd_ptr_i,
    output logic             wr_req_o,
    output tele_addr_t       wr_addr_o,
    output tele_word_t       wr_data_o,
    output tele_level_t      wr_ptr_o,
    output tele_level_t      level_o,
    output logic             overflow_o
);

    tele_sig_t   prev_sig_q;
    logic        prev_en_q;
    tele_level_t alloc_ptr_q;   // Runs one word ahead of wr_ptr while a write is pending
    tele_level_t wr_ptr_q;
    logic        trigger;
    logic        full;

    // A status change or the first enabled cycle records a word
    assign trigger = enable_i && (!prev_en_q || (change_i != prev_sig_q));
    assign full    = (alloc_ptr_q - rd_ptr_i) == tele_level_t'(`TELE_DEPTH);

    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prev_sig_q  <= '0;
            prev_en_q   <= 1'b0;
            alloc_ptr_q <= '0;
            wr_ptr_q    <= '0;
            wr_req_o    <= 1'b0;
            overflow_o  <= 1'b0;
        end else begin
            prev_sig_q <= change_i;
            prev_en_q  <= enable_i;
            wr_req_o   <= trigger && !full;

            if (trigger && !full) begin
                alloc_ptr_q <= alloc_ptr_q + tele_level_t'(1);
            end
            if (trigger && full) begin
                overflow_o <= 1'b1;     // Sticky until reset
            end
            if (wr_req_o) begin
                wr_ptr_q <= wr_ptr_q + tele_level_t'(1);  // Writes are never stalled
            end
        end
    end

    always_ff @(posedge clock) begin
        if (trigger && !full) begin
            wr_addr_o <= alloc_ptr_q[`TELE_ADDR_W-1:0];
            wr_data_o <= {change_i, ignore_i};
        end
    end

    assign wr_ptr_o = wr_ptr_q;
    assign level_o  = wr_ptr_q - rd_ptr_i;

    // The dumper must never read past what has been written
    level_bound_a: assert property (
        @(posedge clock) disable iff (!arst_n_i)
        level_o <= tele_level_t'(`TELE_DEPTH)
    ) else $error("level_o above SRAM depth");

endmodule

`default_nettype wire

/* source/sram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter
    import telemetry_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       arst_n_i,
    input  wire logic       wr_req_i,
    input  wire tele_addr_t wr_addr_i,
    input  wire tele_word_t wr_data_i,
    output logic            wr_gnt_o,
    input  wire logic       rd_req_i,
    input  wire tele_addr_t rd_addr_i,
    output logic            rd_gnt_o,
    output logic            mem_en_o,
    output logic            mem_we_o,
    output tele_addr_t      mem_addr_o,
    output tele_word_t      mem_wdata_o
);

    logic [2:0] starve_cnt_q;   // Cycles a read has waited behind writes

    // Fixed priority with the logger first
    assign wr_gnt_o = wr_req_i;
    assign rd_gnt_o = rd_req_i && !wr_req_i;

    assign mem_en_o    = wr_gnt_o || rd_gnt_o;
    assign mem_we_o    = wr_gnt_o;
    assign mem_addr_o  = wr_gnt_o ? wr_addr_i : rd_addr_i;
    assign mem_wdata_o = wr_data_i;

    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            starve_cnt_q <= '0;
        end else if (rd_req_i && !rd_gnt_o) begin
            if (starve_cnt_q != 3'b111) begin
                starve_cnt_q <= starve_cnt_q + 3'd1;   // Saturates
            end
        end else begin
            starve_cnt_q <= '0;
        end
    end

    one_grant_a: assert property (
        @(posedge clock) disable iff (!arst_n_i)
        !(wr_gnt_o && rd_gnt_o)
    ) else $error("both SRAM grants high");

    // A waiting read must still be held once the writer goes quiet
    starved_read_a: assert property (
        @(posedge clock) disable iff (!arst_n_i)
        (starve_cnt_q != 3'd0 && !wr_req_i) |-> ##[0:2] rd_gnt_o
    ) else $error("held read not granted after writer idle");

endmodule

`default_nettype wire

/* source/telemetry_sram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "telemetry_settings.svh"

module telemetry_sram
    import telemetry_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       en_i,
    input  wire logic       we_i,
    input  wire tele_addr_t addr_i,
    input  wire tele_word_t wdata_i,
    output tele_word_t      rdata_o
);

    tele_word_t mem_q [0:`TELE_DEPTH-1];

    // Single port, read data registered for one cycle of latency
    always_ff @(posedge clock) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

/* source/telemetry_top.sv */
`timescale 1ns/1ps
`default_nettype none

module telemetry_top
    import telemetry_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       arst_n_i,
    input  wire logic       enable_i,
    input  wire tele_sig_t  change_i,
    input  wire tele_ign_t  ignore_i,
    input  wire logic       start_dump_i,
    output logic            is_dumping_o,
    output tele_level_t     level_o,
    output logic            overflow_o,
    output logic            uart_tx_o
);

    logic        wr_req;
    tele_addr_t  wr_addr;
    tele_word_t  wr_data;
    logic        rd_req;
    logic        rd_gnt;
    tele_addr_t  rd_addr;
    tele_word_t  rd_data;
    logic        mem_en;
    logic        mem_we;
    tele_addr_t  mem_addr;
    tele_word_t  mem_wdata;
    tele_level_t wr_ptr;
    tele_level_t rd_ptr;
    logic        char_valid;
    logic        char_ready;
    tele_char_t  char_data;

    change_logger logger_i (
        .clock      (clock),
        .arst_n_i   (arst_n_i),
        .enable_i   (enable_i),
        .change_i   (change_i),
        .ignore_i   (ignore_i),
        .rd_ptr_i   (rd_ptr),
        .wr_req_o   (wr_req),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .wr_ptr_o   (wr_ptr),
        .level_o    (level_o),
        .overflow_o (overflow_o)
    );

    sram_arbiter arbiter_i (
        .clock       (clock),
        .arst_n_i    (arst_n_i),
        .wr_req_i    (wr_req),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .wr_gnt_o    (),            // Logger writes are always granted
        .rd_req_i    (rd_req),
        .rd_addr_i   (rd_addr),
        .rd_gnt_o    (rd_gnt),
        .mem_en_o    (mem_en),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata)
    );

    telemetry_sram sram_i (
        .clock   (clock),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (rd_data)
    );

    hex_dump dumper_i (
        .clock        (clock),
        .arst_n_i     (arst_n_i),
        .start_dump_i (start_dump_i),
        .wr_ptr_i     (wr_ptr),
        .rd_req_o     (rd_req),
        .rd_addr_o    (rd_addr),
        .rd_gnt_i     (rd_gnt),
        .rd_data_i    (rd_data),
        .rd_ptr_o     (rd_ptr),
        .is_dumping_o (is_dumping_o),
        .char_valid_o (char_valid),
        .char_data_o  (char_data),
        .char_ready_i (char_ready)
    );

    uart_tx uart_i (
        .clock        (clock),
        .arst_n_i     (arst_n_i),
        .char_valid_i (char_valid),
        .char_data_i  (char_data),
        .char_ready_o (char_ready),
        .tx_o         (uart_tx_o)
    );

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "telemetry_settings.svh"

module uart_tx
    import telemetry_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       arst_n_i,
    input  wire logic       char_valid_i,
    input  wire tele_char_t char_data_i,
    output logic            char_ready_o,
    output logic            tx_o
);

    localparam int CNT_W = $clog2(`TELE_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`TELE_CLKS_PER_BIT - 1);

    uart_state_t      state_q;
    logic [CNT_W-1:0] baud_cnt_q;
    logic [2:0]       bit_idx_q;
    tele_char_t       shift_q;
    logic             tx_q;
    logic             bit_end;

    assign bit_end      = baud_cnt_q == CNT_LAST;
    assign char_ready_o = state_q == UART_IDLE;   // Low means busy
    assign tx_o         = tx_q;

    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= UART_IDLE;
            bit_idx_q <= '0;
            tx_q      <= 1'b1;
        end else begin
            case (state_q)
                UART_IDLE: begin
                    if (char_valid_i) begin
                        state_q <= UART_START;
                        tx_q    <= 1'b0;        // Start bit
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        state_q   <= UART_DATA;
                        bit_idx_q <= '0;
                        tx_q      <= shift_q[0];
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        if (bit_idx_q == 3'd7) begin
                            state_q <= UART_STOP;
                            tx_q    <= 1'b1;
                        end else begin
                            bit_idx_q <= bit_idx_q + 3'd1;
                            tx_q      <= shift_q[1];    // LSB first
                        end
                    end
                end
                UART_STOP: begin
                    if (bit_end) begin
                        state_q <= UART_IDLE;
                    end
                end
                default: state_q <= UART_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            baud_cnt_q <= '0;
        end else if (state_q == UART_IDLE || bit_end) begin
            baud_cnt_q <= '0;
        end else begin
            baud_cnt_q <= baud_cnt_q + CNT_W'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (char_ready_o && char_valid_i) begin
            shift_q <= char_data_i;
        end else if (state_q == UART_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    idle_line_a: assert property (
        @(posedge clock) disable iff (!arst_n_i)
        state_q == UART_IDLE |-> tx_o
    ) else $error("serial line low while idle");

endmodule

`default_nettype wire

/* tests/telemetry_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "telemetry_settings.svh"

module telemetry_tb
    import telemetry_pkg::*;
();

    localparam int BIT_CLKS  = `TELE_CLKS_PER_BIT;
    localparam int CHAR_CLKS = 10 * BIT_CLKS + 2;   // Frame plus idle gap

    typedef struct packed {
        logic      en;
        tele_sig_t chg;
        tele_ign_t ign;
        int        hold;    // Cycles the row is held, at least 2
        logic      start;
    } row_t;

    logic        clock = 1'b0;
    logic        arst_n_i;
    logic        enable_i;
    tele_sig_t   change_i;
    tele_ign_t   ignore_i;
    logic        start_dump_i;
    logic        is_dumping_o;
    tele_level_t level_o;
    logic        overflow_o;
    logic        uart_tx_o;

    row_t       rows[$];
    tele_word_t model_q[$];     // Words the logger should hold
    tele_char_t exp_chars[$];
    tele_char_t rx_q[$];        // Characters seen on the serial line
    logic       prev_en = 1'b0;
    tele_sig_t  prev_chg = '0;
    logic       exp_overflow = 1'b0;
    logic       dump_pending = 1'b0;
    int         errors_char = 0;
    int         errors_level = 0;
    int         errors_flag = 0;
    int         watchdog_cycles = 0;

    telemetry_top dut_i (
        .clock        (clock),
        .arst_n_i     (arst_n_i),
        .enable_i     (enable_i),
        .change_i     (change_i),
        .ignore_i     (ignore_i),
        .start_dump_i (start_dump_i),
        .is_dumping_o (is_dumping_o),
        .level_o      (level_o),
        .overflow_o   (overflow_o),
        .uart_tx_o    (uart_tx_o)
    );

    always #5 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic tele_char_t ascii_hex(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";
        return tele_char_t'(digits.getc(int'(nib)));
    endfunction

    task automatic check_char(input string name, input tele_char_t exp, input tele_char_t got);
        if (got !== exp) begin
            errors_char++;
            $display("error at %0t: %s expected 0x%02h received 0x%02h", $time, name, exp, got);
        end
    endtask

    task automatic check_level(input string name, input tele_level_t exp, input tele_level_t got);
        if (got !== exp) begin
            errors_level++;
            $display("error at %0t: %s expected %0d received %0d", $time, name, exp, got);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            errors_flag++;
            $display("error at %0t: %s expected %b received %b", $time, name, exp, got);
        end
    endtask

    task automatic add_row(input logic en, input tele_sig_t chg, input tele_ign_t ign,
                           input int hold, input logic start);
        row_t r;
        r.en    = en;
        r.chg   = chg;
        r.ign   = ign;
        r.hold  = hold;
        r.start = start;
        rows.push_back(r);
    endtask

    // Expected characters of every word the dump has snapshotted
    task automatic queue_dump_chars();
        tele_word_t w;
        while (model_q.size() > 0) begin
            w = model_q.pop_front();
            for (int n = 0; n < 8; n++) begin
                exp_chars.push_back(ascii_hex(w[31:28]));
                w = w << 4;
            end
            exp_chars.push_back(8'h0A);
        end
    endtask

    task automatic apply_row(input row_t r);
        logic trigger;
        trigger = r.en && (!prev_en || (r.chg != prev_chg));
        if (trigger) begin
            if (model_q.size() == `TELE_DEPTH) begin
                exp_overflow = 1'b1;    // Dropped, SRAM full
            end else begin
                model_q.push_back({r.chg, r.ign});
            end
        end
        prev_en  = r.en;
        prev_chg = r.chg;

        enable_i     = r.en;
        change_i     = r.chg;
        ignore_i     = r.ign;
        start_dump_i = r.start;
        @(negedge clock);
        start_dump_i = 1'b0;
        if (r.start) begin
            check_flag("is_dumping_o", 1'b1, is_dumping_o);
        end
        repeat (r.hold - 1) @(negedge clock);

        // Level moves while a dump drains the SRAM
        if (!dump_pending) begin
            check_level("level_o", tele_level_t'(model_q.size()), level_o);
            check_flag("overflow_o", exp_overflow, overflow_o);
        end
    endtask

    task automatic finish_dump();
        int exp_rx;
        exp_rx = (exp_chars.size() > 0) ? exp_chars.size() - 1 : 0;
        while (is_dumping_o) @(negedge clock);
        // The last newline is still on the line when the dump ends
        if (rx_q.size() != exp_rx) begin
            errors_flag++;
            $display("error at %0t: is_dumping_o fell after %0d characters, expected %0d",
                     $time, rx_q.size(), exp_rx);
        end
        while (exp_chars.size() > 0) begin
            while (rx_q.size() == 0) @(negedge clock);
            check_char("uart_tx_o", exp_chars.pop_front(), rx_q.pop_front());
        end
        dump_pending = 1'b0;
        check_level("level_o", tele_level_t'(model_q.size()), level_o);
        check_flag("overflow_o", exp_overflow, overflow_o);
    endtask

    // Serial decoder, samples each bit near its middle
    initial begin
        tele_char_t rx;
        wait (arst_n_i === 1'b1);
        forever begin
            @(negedge uart_tx_o);
            repeat (BIT_CLKS / 2) @(negedge clock);
            check_flag("uart_tx_o start bit", 1'b0, uart_tx_o);
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge clock);
                rx[i] = uart_tx_o;      // LSB first
            end
            repeat (BIT_CLKS) @(negedge clock);
            check_flag("uart_tx_o stop bit", 1'b1, uart_tx_o);
            rx_q.push_back(rx);
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("timeout: the run did not end within %0d clock cycles", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [31:0] seed;
        int          total_hold;
        int          n_starts;
        arst_n_i     = 1'b0;
        enable_i     = 1'b0;
        change_i     = '0;
        ignore_i     = '0;
        start_dump_i = 1'b0;
        seed         = 32'h7038d9f2;

        add_row(1'b0, 20'h00000, 12'h000, 3, 1'b1);     // Dump with nothing stored
        add_row(1'b0, 20'h12345, 12'h001, 3, 1'b0);     // Disabled, no word
        add_row(1'b0, 20'h23456, 12'h000, 3, 1'b0);
        add_row(1'b1, 20'h23456, 12'h002, 3, 1'b0);     // Enable rise
        add_row(1'b1, 20'h3A5C7, 12'h0F3, 3, 1'b0);
        add_row(1'b1, 20'h3A5C7, 12'h7FF, 3, 1'b0);     // Ignore field alone
        add_row(1'b1, 20'hFFFFF, 12'h801, 4, 1'b0);
        add_row(1'b0, 20'h00001, 12'h000, 3, 1'b0);
        add_row(1'b1, 20'h00001, 12'h123, 3, 1'b0);
        add_row(1'b1, 20'h00001, 12'h123, 3, 1'b1);
        add_row(1'b1, 20'h0ABCD, 12'h456, 3, 1'b0);     // Recorded during the dump
        add_row(1'b1, 20'h0ABCE, 12'h457, 3, 1'b0);
        add_row(1'b1, 20'hC0FFE, 12'h458, 3, 1'b0);
        add_row(1'b1, 20'hC0FFE, 12'h458, 3, 1'b1);
        add_row(1'b1, 20'hC0FFE, 12'h458, 3, 1'b1);
        for (int i = 0; i < 20; i++) begin
            seed = xorshift32(seed);
            add_row(1'b1, seed[19:0], seed[31:20], 2, 1'b0);
        end
        add_row(1'b1, seed[19:0], 12'h000, 3, 1'b1);

        total_hold = 0;
        n_starts   = 0;
        foreach (rows[i]) begin
            total_hold += rows[i].hold;
            if (rows[i].start) begin
                n_starts++;
            end
        end
        // Every dump could at most drain a full SRAM
        watchdog_cycles = total_hold + (n_starts * `TELE_DEPTH * 9 + 100) * CHAR_CLKS + 1000;

        repeat (2) @(negedge clock);
        arst_n_i = 1'b1;
        @(negedge clock);
        check_flag("uart_tx_o", 1'b1, uart_tx_o);
        check_flag("is_dumping_o", 1'b0, is_dumping_o);
        check_flag("overflow_o", 1'b0, overflow_o);
        check_level("level_o", '0, level_o);

        foreach (rows[i]) begin
            if (rows[i].start && dump_pending) begin
                finish_dump();
            end
            if (rows[i].start) begin
                queue_dump_chars();
                dump_pending = 1'b1;
            end
            apply_row(rows[i]);
            if (rows[i].start && exp_chars.size() == 0) begin
                finish_dump();      // Empty dump ends at once
            end
        end
        if (dump_pending) begin
            finish_dump();
        end

        repeat (2 * CHAR_CLKS) @(negedge clock);
        if (rx_q.size() != 0) begin
            errors_char++;
            $display("%0d unexpected characters received on uart_tx_o", rx_q.size());
        end

        $display("errors: char %0d, level %0d, flag %0d", errors_char, errors_level, errors_flag);
        if (errors_char + errors_level + errors_flag == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
